// ==== design/kcpu_pkg.sv ====
// ====================
// kcpu register section package
// shared value types, CC bit positions and command encodings
// ====================
package kcpu_pkg;

    typedef logic [7:0]  byte_t;
    typedef logic [15:0] word_t;
    typedef logic [7:0]  psh_mask_t;    // cc a b dp x y other pc

    // condition code bits
    localparam int CC_C = 0;
    localparam int CC_V = 1;
    localparam int CC_Z = 2;
    localparam int CC_N = 3;
    localparam int CC_I = 4;
    localparam int CC_H = 5;
    localparam int CC_F = 6;
    localparam int CC_E = 7;

    typedef enum logic [4:0] {
        LDA,
        LDB,
        LDD,
        LDX,
        LDY,
        LDU,
        LDS,
        LDDP,
        ADDA,
        SUBA,
        ANDA,
        ORA,
        ADDD,
        SUBD,
        ORCC,
        ANDCC,
        TFR,        // operand[7:4] source, operand[3:0] destination
        INCX,
        DECB,
        PSH,
        PUL
    } cmd_kind_e;

    typedef struct packed {
        cmd_kind_e kind;
        word_t     operand;
        psh_mask_t mask;
        logic      use_u;       // U stack instead of S
    } cmd_t;

    typedef struct packed {
        byte_t a;
        byte_t b;
        byte_t dp;
        byte_t cc;
        word_t x;
        word_t y;
        word_t u;
        word_t s;
    } reg_view_t;

    typedef enum logic [3:0] {
        ADD8,
        SUB8,
        AND8,
        OR8,
        ADD16,
        SUB16,
        ORCC_OP,
        ANDCC_OP,
        PASS        // transfer source straight through
    } alu_op_e;

endpackage

// ==== design/kcpu_stack_ram.sv ====
`timescale 1ns/1ps
// ====================
// kcpu stack memory
// byte array, synchronous write, registered read
// ====================
module kcpu_stack_ram #(
    parameter int ADDR_W = 8
) (
    input  logic              clk,
    input  logic              wr_en,
    input  logic [ADDR_W-1:0] addr,
    input  kcpu_pkg::byte_t   wdata,
    output kcpu_pkg::byte_t   rdata
);

    kcpu_pkg::byte_t mem [2**ADDR_W];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[addr] <= wdata;
        end
        rdata <= mem[addr];     // data one cycle after the address
    end

endmodule

// ==== design/kcpu_alu.sv ====
`timescale 1ns/1ps
// ====================
// kcpu ALU
// 8/16-bit add, subtract, logic and CC mask operations with flags
// ====================
module kcpu_alu (
    input  kcpu_pkg::alu_op_e alu_op,
    input  kcpu_pkg::word_t   mux_reg0,
    input  kcpu_pkg::word_t   mux_reg1,
    input  kcpu_pkg::word_t   operand,
    input  kcpu_pkg::byte_t   cc,
    output kcpu_pkg::word_t   alu,
    output kcpu_pkg::byte_t   alu_cc
);

    logic [8:0]  sum8, dif8;       // bit 8 is carry or borrow
    logic [16:0] sum16, dif16;

    assign sum8  = {1'b0, mux_reg0[7:0]} + {1'b0, operand[7:0]};
    assign dif8  = {1'b0, mux_reg0[7:0]} - {1'b0, operand[7:0]};
    assign sum16 = {1'b0, mux_reg0} + {1'b0, operand};
    assign dif16 = {1'b0, mux_reg0} - {1'b0, operand};

    always_comb begin
        alu    = mux_reg1;
        alu_cc = cc;
        case (alu_op)
            kcpu_pkg::ADD8: begin
                alu = {8'h00, sum8[7:0]};
                alu_cc[kcpu_pkg::CC_C] = sum8[8];
                alu_cc[kcpu_pkg::CC_V] = (mux_reg0[7] == operand[7]) && (sum8[7] != mux_reg0[7]);
            end
            kcpu_pkg::SUB8: begin
                alu = {8'h00, dif8[7:0]};
                alu_cc[kcpu_pkg::CC_C] = dif8[8];
                alu_cc[kcpu_pkg::CC_V] = (mux_reg0[7] != operand[7]) && (dif8[7] != mux_reg0[7]);
            end
            kcpu_pkg::ADD16: begin
                alu = sum16[15:0];
                alu_cc[kcpu_pkg::CC_C] = sum16[16];
                alu_cc[kcpu_pkg::CC_V] = (mux_reg0[15] == operand[15]) &&
                                         (sum16[15] != mux_reg0[15]);
            end
            kcpu_pkg::SUB16: begin
                alu = dif16[15:0];
                alu_cc[kcpu_pkg::CC_C] = dif16[16];
                alu_cc[kcpu_pkg::CC_V] = (mux_reg0[15] != operand[15]) &&
                                         (dif16[15] != mux_reg0[15]);
            end
            kcpu_pkg::AND8: begin
                alu = {8'h00, mux_reg0[7:0] & operand[7:0]};
                alu_cc[kcpu_pkg::CC_V] = 1'b0;
            end
            kcpu_pkg::OR8: begin
                alu = {8'h00, mux_reg0[7:0] | operand[7:0]};
                alu_cc[kcpu_pkg::CC_V] = 1'b0;
            end
            // mux_reg0 carries CC for the mask forms
            kcpu_pkg::ORCC_OP: begin
                alu    = {8'h00, mux_reg0[7:0] | operand[7:0]};
                alu_cc = alu[7:0];
            end
            kcpu_pkg::ANDCC_OP: begin
                alu    = {8'h00, mux_reg0[7:0] & operand[7:0]};
                alu_cc = alu[7:0];
            end
            default: ;
        endcase
        // N and Z at the result width
        case (alu_op)
            kcpu_pkg::ADD8, kcpu_pkg::SUB8, kcpu_pkg::AND8, kcpu_pkg::OR8: begin
                alu_cc[kcpu_pkg::CC_N] = alu[7];
                alu_cc[kcpu_pkg::CC_Z] = alu[7:0] == 8'h00;
            end
            kcpu_pkg::ADD16, kcpu_pkg::SUB16: begin
                alu_cc[kcpu_pkg::CC_N] = alu[15];
                alu_cc[kcpu_pkg::CC_Z] = alu == 16'h0000;
            end
            default: ;
        endcase
    end

endmodule

// ==== design/kcpu_regs.sv ====
`timescale 1ns/1ps
// ====================
// kcpu register file
// A/B/D, X, Y, U, S, DP, CC with transfer mux and push/pull byte select
// ====================
module kcpu_regs (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  cen,
    input  kcpu_pkg::cmd_kind_e   op,
    input  kcpu_pkg::word_t       mdata,
    input  kcpu_pkg::word_t       alu,
    input  kcpu_pkg::byte_t       alu_cc,
    input  logic                  up_a, up_b, up_d, up_x, up_y, up_u, up_s, up_dp, up_cc,
    input  logic                  inc_x, dec_b, tfr_en,
    input  kcpu_pkg::psh_mask_t   psh_sel,
    input  logic                  psh_hilon,
    input  logic                  psh_ussel,
    input  logic                  pshdec,
    input  logic                  pul_en,
    output kcpu_pkg::word_t       mux_reg0,
    output kcpu_pkg::word_t       mux_reg1,
    output kcpu_pkg::byte_t       psh_mux,
    output kcpu_pkg::psh_mask_t   psh_bit,
    output kcpu_pkg::word_t       psh_addr,
    output kcpu_pkg::reg_view_t   regs
);

    kcpu_pkg::byte_t a, b, dp, cc;
    kcpu_pkg::word_t x, y, u, s;
    kcpu_pkg::word_t nx_u, nx_s, psh_other;
    logic            pul_other;

    assign psh_addr  = psh_ussel ? u : s;
    assign psh_other = psh_ussel ? s : u;     // the pointer that is not the stack in use
    assign pul_other = pul_en && psh_bit[6];

    assign regs = '{a: a, b: b, dp: dp, cc: cc, x: x, y: y, u: u, s: s};

    // accumulator side of the ALU
    always_comb begin
        case (op)
            kcpu_pkg::ADDD, kcpu_pkg::SUBD:  mux_reg0 = {a, b};
            kcpu_pkg::ORCC, kcpu_pkg::ANDCC: mux_reg0 = {8'h00, cc};
            default:                         mux_reg0 = {8'h00, a};
        endcase
    end

    // transfer source, 8-bit registers fill the high byte with FF
    always_comb begin
        case (mdata[7:4])
            4'h0:    mux_reg1 = {8'hFF, a};
            4'h1:    mux_reg1 = {8'hFF, b};
            4'h2:    mux_reg1 = x;
            4'h3:    mux_reg1 = y;
            4'h4:    mux_reg1 = s;
            4'h5:    mux_reg1 = u;
            default: mux_reg1 = '0;
        endcase
    end

    // push takes the highest bit first, pull the lowest, so pull undoes push
    always_comb begin
        psh_bit = '0;
        if (op == kcpu_pkg::PSH) begin
            for (int i = 0; i < 7; i++) begin
                if (psh_sel[i]) psh_bit = kcpu_pkg::psh_mask_t'(1) << i;
            end
        end else begin
            for (int i = 6; i >= 0; i--) begin
                if (psh_sel[i]) psh_bit = kcpu_pkg::psh_mask_t'(1) << i;
            end
        end
    end

    always_comb begin
        case (psh_bit)
            8'h01:   psh_mux = cc;
            8'h02:   psh_mux = a;
            8'h04:   psh_mux = b;
            8'h08:   psh_mux = dp;
            8'h10:   psh_mux = psh_hilon ? x[15:8] : x[7:0];
            8'h20:   psh_mux = psh_hilon ? y[15:8] : y[7:0];
            8'h40:   psh_mux = psh_hilon ? psh_other[15:8] : psh_other[7:0];
            default: psh_mux = 8'h00;
        endcase
    end

    // stack pointer next values
    always_comb begin
        nx_u = u;
        nx_s = s;
        if (up_u) nx_u = mdata;
        if (up_s) nx_s = mdata;
        if (tfr_en && mdata[3:0] == 4'h4) nx_s = alu;
        if (tfr_en && mdata[3:0] == 4'h5) nx_u = alu;
        if (pul_other) begin
            if (psh_ussel && psh_hilon)   nx_s[15:8] = mdata[7:0];
            if (psh_ussel && !psh_hilon)  nx_s[7:0]  = mdata[7:0];
            if (!psh_ussel && psh_hilon)  nx_u[15:8] = mdata[7:0];
            if (!psh_ussel && !psh_hilon) nx_u[7:0]  = mdata[7:0];
        end
        if (pshdec && psh_bit != '0) begin
            if (psh_ussel) nx_u = u - 16'd1;
            else           nx_s = s - 16'd1;
        end
        if (pul_en && psh_bit != '0) begin
            if (psh_ussel) nx_u = u + 16'd1;
            else           nx_s = s + 16'd1;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            a  <= '0;
            b  <= '0;
            dp <= '0;
            cc <= '0;
            x  <= '0;
            y  <= '0;
            u  <= '0;
            s  <= '0;
        end else if (cen) begin
            u <= nx_u;
            s <= nx_s;
            if (up_a)  a <= (op == kcpu_pkg::LDA) ? mdata[7:0] : alu[7:0];
            if (up_b)  b <= mdata[7:0];
            if (up_d)  {a, b} <= (op == kcpu_pkg::LDD) ? mdata : alu;
            if (up_x)  x <= mdata;
            if (up_y)  y <= mdata;
            if (up_dp) dp <= mdata[7:0];
            if (up_cc) cc <= alu_cc;
            if (inc_x) x <= x + 16'd1;       // wraps at FFFF
            if (dec_b) b <= b - 8'd1;
            if (tfr_en) begin
                case (mdata[3:0])
                    4'h0:    a <= alu[7:0];  // low byte only
                    4'h1:    b <= alu[7:0];
                    4'h2:    x <= alu;
                    4'h3:    y <= alu;
                    default: ;
                endcase
            end
            // pulled bytes straight from memory
            if (pul_en) begin
                if (psh_bit[0]) cc <= mdata[7:0];
                if (psh_bit[1]) a  <= mdata[7:0];
                if (psh_bit[2]) b  <= mdata[7:0];
                if (psh_bit[3]) dp <= mdata[7:0];
                if (psh_bit[4] && psh_hilon)  x[15:8] <= mdata[7:0];
                if (psh_bit[4] && !psh_hilon) x[7:0]  <= mdata[7:0];
                if (psh_bit[5] && psh_hilon)  y[15:8] <= mdata[7:0];
                if (psh_bit[5] && !psh_hilon) y[7:0]  <= mdata[7:0];
            end
        end
    end

endmodule

// ==== design/kcpu_ctrl.sv ====
`timescale 1ns/1ps
// ====================
// kcpu controller
// command decode and the push/pull byte sequencer
// ====================
module kcpu_ctrl #(
    parameter int ADDR_W = 8
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  cen,
    input  logic                  cmd_valid,
    input  kcpu_pkg::cmd_t        cmd,
    input  kcpu_pkg::byte_t       psh_mux,
    input  kcpu_pkg::psh_mask_t   psh_bit,
    input  kcpu_pkg::word_t       psh_addr,
    input  kcpu_pkg::byte_t       rdata,
    output logic                  busy,
    output kcpu_pkg::cmd_kind_e   op,
    output kcpu_pkg::alu_op_e     alu_op,
    output kcpu_pkg::word_t       mdata,
    output logic                  up_a, up_b, up_d, up_x, up_y, up_u, up_s, up_dp, up_cc,
    output logic                  inc_x, dec_b, tfr_en,
    output kcpu_pkg::psh_mask_t   psh_sel,
    output logic                  psh_hilon,
    output logic                  psh_ussel,
    output logic                  pshdec,
    output logic                  pul_en,
    output logic                  wr_en,
    output logic [ADDR_W-1:0]     addr,
    output kcpu_pkg::byte_t       wdata
);

    typedef logic [ADDR_W-1:0] stack_addr_t;
    typedef enum logic [1:0] {IDLE, PUSH, PULL_ADDR, PULL_DATA} state_e;

    state_e               state;
    kcpu_pkg::cmd_kind_e  seq_kind;
    logic                 seq_u;
    kcpu_pkg::psh_mask_t  mask, mask_nx;
    logic                 hilon, accept, wide, last_half, first_hilon;

    assign accept = cmd_valid && state == IDLE;
    assign busy   = state != IDLE;
    assign op     = busy ? seq_kind : cmd.kind;

    // single-cycle command strobes
    assign up_a   = accept && (cmd.kind inside {kcpu_pkg::LDA, kcpu_pkg::ADDA, kcpu_pkg::SUBA,
                                                kcpu_pkg::ANDA, kcpu_pkg::ORA});
    assign up_b   = accept && cmd.kind == kcpu_pkg::LDB;
    assign up_d   = accept && (cmd.kind inside {kcpu_pkg::LDD, kcpu_pkg::ADDD, kcpu_pkg::SUBD});
    assign up_x   = accept && cmd.kind == kcpu_pkg::LDX;
    assign up_y   = accept && cmd.kind == kcpu_pkg::LDY;
    assign up_u   = accept && cmd.kind == kcpu_pkg::LDU;
    assign up_s   = accept && cmd.kind == kcpu_pkg::LDS;
    assign up_dp  = accept && cmd.kind == kcpu_pkg::LDDP;
    assign up_cc  = accept && (cmd.kind inside {kcpu_pkg::ADDA, kcpu_pkg::SUBA, kcpu_pkg::ANDA,
                                                kcpu_pkg::ORA, kcpu_pkg::ADDD, kcpu_pkg::SUBD,
                                                kcpu_pkg::ORCC, kcpu_pkg::ANDCC});
    assign inc_x  = accept && cmd.kind == kcpu_pkg::INCX;
    assign dec_b  = accept && cmd.kind == kcpu_pkg::DECB;
    assign tfr_en = accept && cmd.kind == kcpu_pkg::TFR;

    always_comb begin
        case (cmd.kind)
            kcpu_pkg::ADDA:  alu_op = kcpu_pkg::ADD8;
            kcpu_pkg::SUBA:  alu_op = kcpu_pkg::SUB8;
            kcpu_pkg::ANDA:  alu_op = kcpu_pkg::AND8;
            kcpu_pkg::ORA:   alu_op = kcpu_pkg::OR8;
            kcpu_pkg::ADDD:  alu_op = kcpu_pkg::ADD16;
            kcpu_pkg::SUBD:  alu_op = kcpu_pkg::SUB16;
            kcpu_pkg::ORCC:  alu_op = kcpu_pkg::ORCC_OP;
            kcpu_pkg::ANDCC: alu_op = kcpu_pkg::ANDCC_OP;
            default:         alu_op = kcpu_pkg::PASS;
        endcase
    end

    // push goes low byte first, pull high byte first
    assign first_hilon = seq_kind == kcpu_pkg::PUL;
    assign wide        = |psh_bit[6:4];
    assign last_half   = !wide || hilon != first_hilon;
    assign mask_nx     = (psh_bit != '0 && last_half) ? (mask & ~psh_bit) : mask;

    assign psh_sel   = mask;
    assign psh_hilon = hilon;
    assign psh_ussel = seq_u;
    assign pshdec    = state == PUSH && psh_bit != '0;
    assign pul_en    = state == PULL_DATA;
    assign wr_en     = cen && pshdec;
    assign wdata     = psh_mux;
    assign mdata     = pul_en ? {8'h00, rdata} : cmd.operand;
    assign addr      = pshdec ? psh_addr[ADDR_W-1:0] - stack_addr_t'(1) : psh_addr[ADDR_W-1:0];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= IDLE;
            seq_kind <= kcpu_pkg::PSH;
            seq_u    <= 1'b0;
            mask     <= '0;
            hilon    <= 1'b0;
        end else if (cen) begin
            case (state)
                IDLE: if (accept && (cmd.kind inside {kcpu_pkg::PSH, kcpu_pkg::PUL})) begin
                    seq_kind <= cmd.kind;
                    seq_u    <= cmd.use_u;
                    mask     <= cmd.mask & kcpu_pkg::psh_mask_t'(8'h7F);  // no PC
                    hilon    <= cmd.kind == kcpu_pkg::PUL;
                    state    <= (cmd.kind == kcpu_pkg::PSH) ? PUSH : PULL_ADDR;
                end
                PULL_ADDR: state <= (psh_bit == '0) ? IDLE : PULL_DATA;
                default: begin              // PUSH and PULL_DATA finish one byte
                    mask  <= mask_nx;
                    hilon <= last_half ? first_hilon : ~hilon;
                    if (mask_nx == '0)       state <= IDLE;
                    else if (state != PUSH)  state <= PULL_ADDR;
                end
            endcase
        end
    end

endmodule

// ==== design/kcpu_regs_top.sv ====
`timescale 1ns/1ps
// ====================
// kcpu register section top
// controller, register file, ALU and stack memory
// ====================
module kcpu_regs_top #(
    parameter int ADDR_W = 8
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                cen,
    input  logic                cmd_valid,
    input  kcpu_pkg::cmd_t      cmd,
    output logic                busy,
    output kcpu_pkg::reg_view_t regs
);

    kcpu_pkg::cmd_kind_e op;
    kcpu_pkg::alu_op_e   alu_op;
    kcpu_pkg::word_t     mdata, alu, mux_reg0, mux_reg1, psh_addr;
    kcpu_pkg::byte_t     alu_cc, psh_mux, wdata, rdata;
    kcpu_pkg::psh_mask_t psh_sel, psh_bit;
    logic                up_a, up_b, up_d, up_x, up_y, up_u, up_s, up_dp, up_cc;
    logic                inc_x, dec_b, tfr_en;
    logic                psh_hilon, psh_ussel, pshdec, pul_en, wr_en;
    logic [ADDR_W-1:0]   addr;

    kcpu_ctrl #(.ADDR_W(ADDR_W)) u_ctrl (
        .clk, .rst, .cen, .cmd_valid, .cmd,
        .psh_mux, .psh_bit, .psh_addr, .rdata,
        .busy, .op, .alu_op, .mdata,
        .up_a, .up_b, .up_d, .up_x, .up_y, .up_u, .up_s, .up_dp, .up_cc,
        .inc_x, .dec_b, .tfr_en,
        .psh_sel, .psh_hilon, .psh_ussel, .pshdec, .pul_en,
        .wr_en, .addr, .wdata
    );

    kcpu_regs u_regs (
        .clk, .rst, .cen, .op, .mdata, .alu, .alu_cc,
        .up_a, .up_b, .up_d, .up_x, .up_y, .up_u, .up_s, .up_dp, .up_cc,
        .inc_x, .dec_b, .tfr_en,
        .psh_sel, .psh_hilon, .psh_ussel, .pshdec, .pul_en,
        .mux_reg0, .mux_reg1, .psh_mux, .psh_bit, .psh_addr, .regs
    );

    kcpu_alu u_alu (
        .alu_op,
        .mux_reg0,
        .mux_reg1,
        .operand (mdata),
        .cc      (regs.cc),
        .alu,
        .alu_cc
    );

    kcpu_stack_ram #(.ADDR_W(ADDR_W)) u_ram (
        .clk,
        .wr_en,
        .addr,
        .wdata,
        .rdata
    );

endmodule

// ==== dv/kcpu_regs_tb_table.svh ====
// ====================
// kcpu register section test table
// command steps with expected register view
// ====================

// each row gives name, command, operand, push/pull mask, flags and expected registers
// flags are {use_u, cen, hold, random operand}
// a held row lets the next command land while busy
// expected view is a_b_dp_cc_x_y_u_s
// it is ignored on held and random rows
task automatic fill_table();
    // loads of every register
    row("lda", kcpu_pkg::LDA, 16'h0011, 8'h00, 4'b0100, 96'h11_00_00_00_0000_0000_0000_0000);
    row("ldb", kcpu_pkg::LDB, 16'h0022, 8'h00, 4'b0100, 96'h11_22_00_00_0000_0000_0000_0000);
    row("ldd", kcpu_pkg::LDD, 16'h3344, 8'h00, 4'b0100, 96'h33_44_00_00_0000_0000_0000_0000);
    row("lddp", kcpu_pkg::LDDP, 16'h0055, 8'h00, 4'b0100, 96'h33_44_55_00_0000_0000_0000_0000);
    row("ldx", kcpu_pkg::LDX, 16'h1234, 8'h00, 4'b0100, 96'h33_44_55_00_1234_0000_0000_0000);
    row("ldy", kcpu_pkg::LDY, 16'h5678, 8'h00, 4'b0100, 96'h33_44_55_00_1234_5678_0000_0000);
    row("ldu", kcpu_pkg::LDU, 16'h9abc, 8'h00, 4'b0100, 96'h33_44_55_00_1234_5678_9abc_0000);
    row("lds", kcpu_pkg::LDS, 16'h0080, 8'h00, 4'b0100, 96'h33_44_55_00_1234_5678_9abc_0080);
    // transfers where an 8-bit source reads FF in the high byte
    row("tfr_ax", kcpu_pkg::TFR, 16'h0002, 8'h00, 4'b0100, 96'h33_44_55_00_ff33_5678_9abc_0080);
    row("tfr_xb", kcpu_pkg::TFR, 16'h0021, 8'h00, 4'b0100, 96'h33_33_55_00_ff33_5678_9abc_0080);
    row("tfr_sy", kcpu_pkg::TFR, 16'h0043, 8'h00, 4'b0100, 96'h33_33_55_00_ff33_0080_9abc_0080);
    row("tfr_ua", kcpu_pkg::TFR, 16'h0050, 8'h00, 4'b0100, 96'hbc_33_55_00_ff33_0080_9abc_0080);
    // CC masks and logic ops
    row("orcc", kcpu_pkg::ORCC, 16'h005b, 8'h00, 4'b0100, 96'hbc_33_55_5b_ff33_0080_9abc_0080);
    row("andcc", kcpu_pkg::ANDCC, 16'h00f3, 8'h00, 4'b0100, 96'hbc_33_55_53_ff33_0080_9abc_0080);
    row("anda", kcpu_pkg::ANDA, 16'h000f, 8'h00, 4'b0100, 96'h0c_33_55_51_ff33_0080_9abc_0080);
    row("ora", kcpu_pkg::ORA, 16'h0080, 8'h00, 4'b0100, 96'h8c_33_55_59_ff33_0080_9abc_0080);
    row("anda_z", kcpu_pkg::ANDA, 16'h0000, 8'h00, 4'b0100, 96'h00_33_55_55_ff33_0080_9abc_0080);
    row("andcc_c", kcpu_pkg::ANDCC, 16'h00fe, 8'h00, 4'b0100, 96'h00_33_55_54_ff33_0080_9abc_0080);
    // full push and pull on S
    row("psh_s", kcpu_pkg::PSH, 16'h0000, 8'hff, 4'b0100, 96'h00_33_55_54_ff33_0080_9abc_0076);
    row("clr_d", kcpu_pkg::LDD, 16'hffff, 8'h00, 4'b0100, 96'hff_ff_55_54_ff33_0080_9abc_0076);
    row("clr_x", kcpu_pkg::LDX, 16'h0000, 8'h00, 4'b0100, 96'hff_ff_55_54_0000_0080_9abc_0076);
    row("clr_u", kcpu_pkg::LDU, 16'h0000, 8'h00, 4'b0100, 96'hff_ff_55_54_0000_0080_0000_0076);
    row("clr_cc", kcpu_pkg::ANDCC, 16'h0000, 8'h00, 4'b0100, 96'hff_ff_55_00_0000_0080_0000_0076);
    row("pul_s", kcpu_pkg::PUL, 16'h0000, 8'hff, 4'b0100, 96'h00_33_55_54_ff33_0080_9abc_0080);
    // full push and pull on U with S as the other pointer
    row("ldu_2", kcpu_pkg::LDU, 16'h0040, 8'h00, 4'b0100, 96'h00_33_55_54_ff33_0080_0040_0080);
    row("psh_u", kcpu_pkg::PSH, 16'h0000, 8'hff, 4'b1100, 96'h00_33_55_54_ff33_0080_0036_0080);
    row("clr_s", kcpu_pkg::LDS, 16'h0000, 8'h00, 4'b0100, 96'h00_33_55_54_ff33_0080_0036_0000);
    row("clr_x2", kcpu_pkg::LDX, 16'h1111, 8'h00, 4'b0100, 96'h00_33_55_54_1111_0080_0036_0000);
    row("pul_u", kcpu_pkg::PUL, 16'h0000, 8'hff, 4'b1100, 96'h00_33_55_54_ff33_0080_0040_0080);
    // cen low, wrap-around, empty mask, command during busy
    row("cen_lo", kcpu_pkg::LDA, 16'h0099, 8'h00, 4'b0000, 96'h00_33_55_54_ff33_0080_0040_0080);
    row("ldx_ff", kcpu_pkg::LDX, 16'hffff, 8'h00, 4'b0100, 96'h00_33_55_54_ffff_0080_0040_0080);
    row("incx", kcpu_pkg::INCX, 16'h0000, 8'h00, 4'b0100, 96'h00_33_55_54_0000_0080_0040_0080);
    row("ldb_0", kcpu_pkg::LDB, 16'h0000, 8'h00, 4'b0100, 96'h00_00_55_54_0000_0080_0040_0080);
    row("decb", kcpu_pkg::DECB, 16'h0000, 8'h00, 4'b0100, 96'h00_ff_55_54_0000_0080_0040_0080);
    row("psh_0", kcpu_pkg::PSH, 16'h0000, 8'h80, 4'b0100, 96'h00_ff_55_54_0000_0080_0040_0080);
    row("psh_xy", kcpu_pkg::PSH, 16'h0000, 8'h30, 4'b0110, 96'h0);
    row("lda_bsy", kcpu_pkg::LDA, 16'h0077, 8'h00, 4'b0100, 96'h00_ff_55_54_0000_0080_0040_007c);
    // random operands checked against the model
    row("adda_r1", kcpu_pkg::ADDA, 16'h0000, 8'h00, 4'b0101, 96'h0);
    row("suba_r1", kcpu_pkg::SUBA, 16'h0000, 8'h00, 4'b0101, 96'h0);
    row("adda_r2", kcpu_pkg::ADDA, 16'h0000, 8'h00, 4'b0101, 96'h0);
    row("suba_r2", kcpu_pkg::SUBA, 16'h0000, 8'h00, 4'b0101, 96'h0);
    row("addd_r1", kcpu_pkg::ADDD, 16'h0000, 8'h00, 4'b0101, 96'h0);
    row("subd_r1", kcpu_pkg::SUBD, 16'h0000, 8'h00, 4'b0101, 96'h0);
    row("addd_r2", kcpu_pkg::ADDD, 16'h0000, 8'h00, 4'b0101, 96'h0);
    row("subd_r2", kcpu_pkg::SUBD, 16'h0000, 8'h00, 4'b0101, 96'h0);
endtask

// ==== dv/kcpu_regs_tb.sv ====
`timescale 1ns/1ps
// ====================
// kcpu register section testbench
// table of command steps checked against the register view
// ====================
module kcpu_regs_tb;

    localparam int CLK_NS     = 4;
    localparam int ROW_CYCLES = 40;    // watchdog budget per row

    typedef struct {
        string               name;
        kcpu_pkg::cmd_t      cmd;
        logic [3:0]          flags;    // use_u, cen, hold, random operand
        kcpu_pkg::reg_view_t exp;
    } step_t;

    logic                clk;
    logic                rst;
    logic                cen;
    logic                cmd_valid;
    kcpu_pkg::cmd_t      cmd;
    logic                busy;
    kcpu_pkg::reg_view_t regs;

    step_t               steps[$];
    kcpu_pkg::reg_view_t model;
    int                  seed = 29825;
    int                  checks;
    int                  errors;
    bit                  table_ready;

    kcpu_regs_top #(.ADDR_W(8)) u_dut (
        .clk, .rst, .cen, .cmd_valid, .cmd, .busy, .regs
    );

    task automatic row(input string name, input kcpu_pkg::cmd_kind_e kind,
                       input kcpu_pkg::word_t operand, input kcpu_pkg::psh_mask_t mask,
                       input logic [3:0] flags, input kcpu_pkg::reg_view_t exp);
        step_t s;
        s.name        = name;
        s.cmd.kind    = kind;
        s.cmd.operand = operand;
        s.cmd.mask    = mask;
        s.cmd.use_u   = flags[3];
        s.flags       = flags;
        s.exp         = exp;
        steps.push_back(s);
    endtask

    `include "kcpu_regs_tb_table.svh"

    // expected flags at the result width with V from the signed range
    function automatic kcpu_pkg::reg_view_t alu_model(input kcpu_pkg::reg_view_t m,
                                                      input kcpu_pkg::cmd_kind_e kind,
                                                      input kcpu_pkg::word_t opnd);
        kcpu_pkg::reg_view_t r;
        kcpu_pkg::word_t     d;
        kcpu_pkg::word_t     res;
        int                  sres;
        logic                c;
        logic                v;
        r   = m;
        d   = {m.a, m.b};
        res = '0;
        c   = 1'b0;
        v   = 1'b0;
        case (kind)
            kcpu_pkg::ADDA: begin
                res[7:0] = m.a + opnd[7:0];
                c        = (int'(m.a) + int'(opnd[7:0])) > 255;
                sres     = int'($signed(m.a)) + int'($signed(opnd[7:0]));
                v        = (sres > 127) || (sres < -128);
                r.a      = res[7:0];
            end
            kcpu_pkg::SUBA: begin
                res[7:0] = m.a - opnd[7:0];
                c        = m.a < opnd[7:0];
                sres     = int'($signed(m.a)) - int'($signed(opnd[7:0]));
                v        = (sres > 127) || (sres < -128);
                r.a      = res[7:0];
            end
            kcpu_pkg::ADDD: begin
                res   = d + opnd;
                c     = (int'(d) + int'(opnd)) > 65535;
                sres  = int'($signed(d)) + int'($signed(opnd));
                v     = (sres > 32767) || (sres < -32768);
                r.a   = res[15:8];
                r.b   = res[7:0];
            end
            default: begin
                res   = d - opnd;
                c     = d < opnd;
                sres  = int'($signed(d)) - int'($signed(opnd));
                v     = (sres > 32767) || (sres < -32768);
                r.a   = res[15:8];
                r.b   = res[7:0];
            end
        endcase
        if (kind == kcpu_pkg::ADDA || kind == kcpu_pkg::SUBA) begin
            r.cc[kcpu_pkg::CC_N] = res[7];
            r.cc[kcpu_pkg::CC_Z] = res[7:0] == 8'h00;
        end else begin
            r.cc[kcpu_pkg::CC_N] = res[15];
            r.cc[kcpu_pkg::CC_Z] = res == 16'h0000;
        end
        r.cc[kcpu_pkg::CC_V] = v;
        r.cc[kcpu_pkg::CC_C] = c;
        return r;
    endfunction

    // busy cycles from the mask byte count without the PC bit
    function automatic int expected_busy(input kcpu_pkg::cmd_t c);
        int bytes;
        bytes = 0;
        for (int i = 0; i < 7; i++) begin
            if (c.mask[i]) begin
                bytes += (i >= 4) ? 2 : 1;    // X, Y and the other pointer are words
            end
        end
        if (c.kind == kcpu_pkg::PSH) begin
            return (bytes == 0) ? 1 : bytes;
        end
        if (c.kind == kcpu_pkg::PUL) begin
            return (bytes == 0) ? 1 : 2 * bytes;    // address cycle and data cycle
        end
        return 0;
    endfunction

    task automatic check(input string name, input logic [95:0] exp, input logic [95:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("error %s: expected %h actual %h", name, exp, act);
        end
    endtask

    // strobe one command and raise cen again afterwards
    task automatic apply(input step_t s);
        @(posedge clk);
        cmd_valid <= 1'b1;
        cmd       <= s.cmd;
        cen       <= s.flags[2];
        @(posedge clk);
        cmd_valid <= 1'b0;
        cen       <= 1'b1;
    endtask

    task automatic wait_idle(output int cycles);
        cycles = 0;
        @(negedge clk);
        while (busy) begin
            cycles++;
            @(negedge clk);
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #(CLK_NS / 2) clk = ~clk;
    end

    initial begin
        wait (table_ready);
        #((steps.size() + 2) * ROW_CYCLES * CLK_NS);
        $display("watchdog expired, the run did not finish in time");
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        step_t s;
        int    busy_cnt;
        int    errors_before;
        bit    held;
        rst       = 1'b1;
        cen       = 1'b0;
        cmd_valid = 1'b0;
        cmd       = '0;
        checks    = 0;
        errors    = 0;
        model     = '0;
        held      = 1'b0;
        fill_table();
        table_ready = 1'b1;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        cen <= 1'b1;
        foreach (steps[i]) begin
            s = steps[i];
            if (s.flags[0]) begin
                s.cmd.operand = kcpu_pkg::word_t'($random(seed));
                s.exp         = alu_model(model, s.cmd.kind, s.cmd.operand);
            end
            apply(s);
            if (s.flags[1]) begin
                $display("issued %s, next command lands while busy", s.name);
                held = 1'b1;
            end else begin
                errors_before = errors;
                wait_idle(busy_cnt);
                check(s.name, s.exp, regs);
                // the busy count of a row after a held one includes the held sequence
                if (!held) begin
                    check({s.name, " busy"}, 96'(expected_busy(s.cmd)), 96'(busy_cnt));
                end
                held  = 1'b0;
                model = s.exp;
                $display("%s %s", (errors == errors_before) ? "pass" : "fail", s.name);
            end
        end
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== kcpu_regs_top.f ====
+incdir+dv
design/kcpu_pkg.sv
design/kcpu_stack_ram.sv
design/kcpu_alu.sv
design/kcpu_regs.sv
design/kcpu_ctrl.sv
design/kcpu_regs_top.sv
dv/kcpu_regs_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary -sv --timing
TOP       = kcpu_regs_tb
FLIST     = kcpu_regs_top.f
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	grep -q "TEST OK" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
